// File: logic/rvCorePkg.sv
/* RV32I multicycle core definitions */

package rvCorePkg;

  typedef enum logic [6:0] {
    opRType     = 7'b0110011,
    opITypeAlu  = 7'b0010011,
    opITypeLoad = 7'b0000011,
    opSType     = 7'b0100011,
    opBType     = 7'b1100011,
    opJal       = 7'b1101111,
    opJalr      = 7'b1100111,
    opLui       = 7'b0110111,
    opAuipc     = 7'b0010111,
    opMiscMem   = 7'b0001111, // fence, runs as a no-op
    opSystem    = 7'b1110011
  } opcodeT;

  typedef enum logic [4:0] {
    stFetch, stDecode, stExecuteR, stExecuteI, stUncondJump,
    stMemAdr, stMemRead, stMemWb, stMemWrite, stBranchEval,
    stLui, stAuipc, stJalrCalc, stJalrLink, stAluWb
  } fsmStateT;

  typedef enum logic {adrPc, adrResult} adrSrcT;
  typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARs1, srcAZero} aluSrcAT;
  typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} aluSrcBT;
  typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSrcT;
  typedef enum logic [1:0] {pcIncrement, pcJump, pcAluOut} pcSrcT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluPassB
  } aluOpT;

  // one instruction word, viewed per encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcodeT     opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcodeT      opcode;
    } i;
    struct packed {
      logic [6:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLow;
      opcodeT     opcode;
    } s;
    struct packed {
      logic       immSign;
      logic [5:0] immMid;   // imm[10:5]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLow;   // imm[4:1]
      logic       immBit11;
      opcodeT     opcode;
    } b;
    struct packed {
      logic [19:0] immUpper;
      logic [4:0]  rd;
      opcodeT      opcode;
    } u;
    struct packed {
      logic       immSign;
      logic [9:0] immLow;   // imm[10:1]
      logic       immBit11;
      logic [7:0] immHigh;  // imm[19:12]
      logic [4:0] rd;
      opcodeT     opcode;
    } j;
  } instrT;

endpackage

// File: logic/coreCtrlIf.sv
/* Control to datapath link */

`timescale 1ns/1ps

interface coreCtrlIf
  import rvCorePkg::*;
();

  logic      irWrite;
  logic      pcUpdate;
  pcSrcT     pcSrc;
  logic      regWrite;
  adrSrcT    adrSrc;
  aluSrcAT   aluSrcA;
  aluSrcBT   aluSrcB;
  aluOpT     aluOp;
  resultSrcT resultSrc;
  logic [3:0] memStrobe; // all ones only while a store is on the bus

  instrT instr;   // instruction register contents
  logic  zeroFlag;
  logic  aluLsb;  // slt/sltu outcome for the ordered branches

  modport ctrl (
    output irWrite, pcUpdate, pcSrc, regWrite, adrSrc,
    output aluSrcA, aluSrcB, aluOp, resultSrc, memStrobe,
    input  instr, zeroFlag, aluLsb
  );

  modport dp (
    input  irWrite, pcUpdate, pcSrc, regWrite, adrSrc,
    input  aluSrcA, aluSrcB, aluOp, resultSrc, memStrobe,
    output instr, zeroFlag, aluLsb
  );

endinterface

// File: logic/regFile.sv
/* Register file */

`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  input  logic [4:0]  writeAddr,
  input  logic        writeEnable,
  input  logic [31:0] writeData,
  output logic [31:0] readDataA,
  output logic [31:0] readDataB
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (writeEnable && writeAddr != 5'd0) begin
      regs[writeAddr] <= writeData; // x0 stays zero
    end
  end

  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

// File: logic/alu.sv
/* RV32I ALU */

`timescale 1ns/1ps

module alu
  import rvCorePkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpT       op,
  output logic [31:0] result,
  output logic        zero
);

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluSll:   result = a << b[4:0];
      aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
      aluSltu:  result = {31'b0, a < b};
      aluXor:   result = a ^ b;
      aluSrl:   result = a >> b[4:0];
      aluSra:   result = $unsigned($signed(a) >>> b[4:0]);
      aluOr:    result = a | b;
      aluAnd:   result = a & b;
      aluPassB: result = b; // lui
      default:  result = a + b;
    endcase
  end

  assign zero = (result == 32'h0);

endmodule

// File: logic/controlFsm.sv
/* Multicycle control FSM */

`timescale 1ns/1ps

module controlFsm
  import rvCorePkg::*;
(
  input  logic clk,
  input  logic reset,
  coreCtrlIf.ctrl ctrl,
  output logic memReq,
  output logic memWrite,
  input  logic memDone
);

  fsmStateT state;
  fsmStateT nextState;
  opcodeT   opcode;
  logic [2:0] funct3;
  logic     branchTaken;

  assign opcode = ctrl.instr.r.opcode;
  assign funct3 = ctrl.instr.r.funct3;

  // funct7 bit 5 picks sub/sra, but addi has no sub form
  function automatic aluOpT decodeAluOp(logic [2:0] f3, logic f7b5, logic isReg);
    aluOpT op;
    case (f3)
      3'b000:  op = (isReg && f7b5) ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = f7b5 ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    return op;
  endfunction

  always_comb begin
    case (funct3)
      3'b000:         branchTaken = ctrl.zeroFlag;  // beq
      3'b001:         branchTaken = !ctrl.zeroFlag; // bne
      3'b100, 3'b110: branchTaken = ctrl.aluLsb;    // blt, bltu
      3'b101, 3'b111: branchTaken = !ctrl.aluLsb;   // bge, bgeu
      default:        branchTaken = 1'b0;
    endcase
  end

  always_comb begin
    nextState = stFetch;
    case (state)
      stFetch:  nextState = memDone ? stDecode : stFetch;
      stDecode: begin
        case (opcode)
          opRType:                nextState = stExecuteR;
          opITypeAlu:             nextState = stExecuteI;
          opITypeLoad, opSType:   nextState = stMemAdr;
          opBType:                nextState = stBranchEval;
          opJal:                  nextState = stUncondJump;
          opJalr:                 nextState = stJalrCalc;
          opLui:                  nextState = stLui;
          opAuipc:                nextState = stAuipc;
          default:                nextState = stFetch; // fence, system, unknown
        endcase
      end
      stMemAdr:     nextState = (opcode == opITypeLoad) ? stMemRead : stMemWrite;
      stMemRead:    nextState = memDone ? stMemWb : stMemRead;
      stMemWrite:   nextState = memDone ? stFetch : stMemWrite;
      stJalrCalc:   nextState = stJalrLink;
      stExecuteR, stExecuteI, stUncondJump, stLui, stAuipc, stJalrLink:
        nextState = stAluWb;
      default:      nextState = stFetch; // memWb, branchEval, aluWb
    endcase
  end

  always_comb begin
    ctrl.irWrite   = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.pcSrc     = pcIncrement;
    ctrl.regWrite  = 1'b0;
    ctrl.adrSrc    = adrPc;
    ctrl.aluSrcA   = srcAPc;
    ctrl.aluSrcB   = srcBFour;
    ctrl.aluOp     = aluAdd;
    ctrl.resultSrc = resAluOut;
    ctrl.memStrobe = 4'b0000;
    memReq   = 1'b0;
    memWrite = 1'b0;
    case (state)
      stFetch: begin
        memReq        = 1'b1;
        ctrl.irWrite  = memDone; // alu forms pc + 4 meanwhile
        ctrl.pcUpdate = memDone;
      end
      stDecode: begin // branch and jal target into aluOut
        ctrl.aluSrcA = srcAOldPc;
        ctrl.aluSrcB = srcBImm;
      end
      stExecuteR: begin
        ctrl.aluSrcA = srcARs1;
        ctrl.aluSrcB = srcBRs2;
        ctrl.aluOp   = decodeAluOp(funct3, ctrl.instr.r.funct7[5], 1'b1);
      end
      stExecuteI: begin
        ctrl.aluSrcA = srcARs1;
        ctrl.aluSrcB = srcBImm;
        ctrl.aluOp   = decodeAluOp(funct3, ctrl.instr.r.funct7[5], 1'b0);
      end
      stUncondJump: begin
        ctrl.aluSrcA  = srcAOldPc; // link value
        ctrl.pcSrc    = pcJump;
        ctrl.pcUpdate = 1'b1;
      end
      stMemAdr, stJalrCalc: begin
        ctrl.aluSrcA = srcARs1;
        ctrl.aluSrcB = srcBImm;
      end
      stMemRead: begin
        memReq      = 1'b1;
        ctrl.adrSrc = adrResult;
      end
      stMemWrite: begin
        memReq         = 1'b1;
        memWrite       = 1'b1;
        ctrl.adrSrc    = adrResult;
        ctrl.memStrobe = 4'b1111;
      end
      stMemWb: begin
        ctrl.resultSrc = resData;
        ctrl.regWrite  = 1'b1;
      end
      stBranchEval: begin
        ctrl.aluSrcA  = srcARs1;
        ctrl.aluSrcB  = srcBRs2;
        ctrl.aluOp    = funct3[2] ? (funct3[1] ? aluSltu : aluSlt) : aluSub;
        ctrl.pcSrc    = pcJump;
        ctrl.pcUpdate = branchTaken;
      end
      stLui: begin
        ctrl.aluSrcA = srcAZero;
        ctrl.aluSrcB = srcBImm;
        ctrl.aluOp   = aluPassB;
      end
      stAuipc: begin
        ctrl.aluSrcA = srcAOldPc;
        ctrl.aluSrcB = srcBImm;
      end
      stJalrLink: begin
        ctrl.aluSrcA  = srcAOldPc;
        ctrl.pcSrc    = pcAluOut; // rs1 + imm from jalrCalc, bit 0 dropped
        ctrl.pcUpdate = 1'b1;
      end
      stAluWb: ctrl.regWrite = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= stFetch;
    else       state <= nextState;
  end

  stateLegal: assert property (@(posedge clk) disable iff (reset)
    state inside {stFetch, stDecode, stExecuteR, stExecuteI, stUncondJump,
                  stMemAdr, stMemRead, stMemWb, stMemWrite, stBranchEval,
                  stLui, stAuipc, stJalrCalc, stJalrLink, stAluWb});

endmodule

// File: logic/datapath.sv
/* Multicycle datapath */

`timescale 1ns/1ps

module datapath
  import rvCorePkg::*;
#(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,
  coreCtrlIf.dp       dp,
  output logic [31:0] memAddr,
  output logic [31:0] memWdata,
  output logic [3:0]  memStrobeOut,
  input  logic [31:0] memRdata,
  input  logic        memDone
);

  logic [31:0] pc;
  logic [31:0] oldPc;
  instrT       instrReg;
  logic [31:0] aReg;
  logic [31:0] bReg;
  logic [31:0] aluOut;
  logic [31:0] dataReg;
  logic [31:0] rdA;
  logic [31:0] rdB;
  logic [31:0] imm;
  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] aluResult;
  logic [31:0] result;
  logic [31:0] nextPc;
  logic [3:0]  laneMask;

  assign dp.instr  = instrReg;
  assign dp.aluLsb = aluResult[0];

  regFile i_regFile (
    .clk        (clk),
    .reset      (reset),
    .readAddrA  (instrReg.r.rs1),
    .readAddrB  (instrReg.r.rs2),
    .writeAddr  (instrReg.r.rd),
    .writeEnable(dp.regWrite),
    .writeData  (result),
    .readDataA  (rdA),
    .readDataB  (rdB)
  );

  // immediate by format
  always_comb begin
    case (instrReg.r.opcode)
      opSType: imm = {{20{instrReg.s.immHigh[6]}}, instrReg.s.immHigh, instrReg.s.immLow};
      opBType: imm = {{20{instrReg.b.immSign}}, instrReg.b.immBit11,
                      instrReg.b.immMid, instrReg.b.immLow, 1'b0};
      opLui, opAuipc: imm = {instrReg.u.immUpper, 12'h000};
      opJal:   imm = {{12{instrReg.j.immSign}}, instrReg.j.immHigh,
                      instrReg.j.immBit11, instrReg.j.immLow, 1'b0};
      default: imm = {{20{instrReg.i.imm[11]}}, instrReg.i.imm};
    endcase
  end

  always_comb begin
    case (dp.aluSrcA)
      srcAPc:    srcA = pc;
      srcAOldPc: srcA = oldPc;
      srcARs1:   srcA = aReg;
      default:   srcA = 32'h0;
    endcase
    case (dp.aluSrcB)
      srcBRs2: srcB = bReg;
      srcBImm: srcB = imm;
      default: srcB = 32'd4;
    endcase
  end

  alu i_alu (
    .a     (srcA),
    .b     (srcB),
    .op    (dp.aluOp),
    .result(aluResult),
    .zero  (dp.zeroFlag)
  );

  always_comb begin
    case (dp.resultSrc)
      resAluOut: result = aluOut;
      resData:   result = dataReg;
      default:   result = aluResult;
    endcase
    case (dp.pcSrc)
      pcJump:   nextPc = aluOut;
      pcAluOut: nextPc = {aluOut[31:1], 1'b0};
      default:  nextPc = aluResult; // pc + 4 formed during fetch
    endcase
  end

  assign memAddr = (dp.adrSrc == adrPc) ? pc : result;

  // sb/sh land in the addressed byte lanes
  always_comb begin
    case (instrReg.s.funct3)
      3'b000:  laneMask = 4'b0001 << memAddr[1:0];
      3'b001:  laneMask = 4'b0011 << memAddr[1:0];
      default: laneMask = 4'b1111;
    endcase
  end

  assign memWdata     = bReg << {memAddr[1:0], 3'b000};
  assign memStrobeOut = dp.memStrobe & laneMask;

  always_ff @(posedge clk) begin
    if (reset)            pc <= resetVector;
    else if (dp.pcUpdate) pc <= nextPc;
  end

  always_ff @(posedge clk) begin
    if (dp.irWrite) begin
      instrReg <= memRdata;
      oldPc    <= pc;
    end
    if (memDone) dataReg <= memRdata;
    aReg   <= rdA;
    bReg   <= rdB;
    aluOut <= aluResult;
  end

  pcAligned: assert property (@(posedge clk) disable iff (reset)
    dp.pcUpdate |=> pc[1:0] == 2'b00);

endmodule

// File: logic/apbRequester.sv
/* APB requester */

`timescale 1ns/1ps

module apbRequester (
  input  logic        clk,
  input  logic        reset,
  input  logic        memReq,
  input  logic        memWrite,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWdata,
  input  logic [3:0]  memStrobe,
  output logic        memDone,
  output logic [31:0] memRdata,
  output logic [31:0] paddr,
  output logic        psel,
  output logic        penable,
  output logic        pwrite,
  output logic [31:0] pwdata,
  output logic [3:0]  pstrb,
  input  logic [31:0] prdata,
  input  logic        pready
);

  localparam logic [1:0] reqIdle   = 2'd0;
  localparam logic [1:0] reqSetup  = 2'd1;
  localparam logic [1:0] reqAccess = 2'd2;

  logic [1:0] state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= reqIdle;
    end else begin
      case (state)
        reqIdle:   if (memReq) state <= reqSetup;
        reqSetup:  state <= reqAccess;
        reqAccess: if (pready) state <= reqIdle; // psel falls next cycle
        default:   state <= reqIdle;
      endcase
    end
  end

  // request captured as the setup phase opens
  always_ff @(posedge clk) begin
    if (state == reqIdle && memReq) begin
      paddr  <= memAddr;
      pwrite <= memWrite;
      pwdata <= memWdata;
      pstrb  <= memWrite ? memStrobe : 4'b0000;
    end
  end

  assign psel     = (state != reqIdle);
  assign penable  = (state == reqAccess);
  assign memDone  = penable && pready;
  assign memRdata = prdata;

  enableInSel: assert property (@(posedge clk) disable iff (reset) penable |-> psel);

  holdWhileWait: assert property (@(posedge clk) disable iff (reset)
    penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

// File: logic/rvMulticycle.sv
/* RV32I multicycle core, APB memory port */

`timescale 1ns/1ps

module rvMulticycle #(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] paddr,
  output logic        psel,
  output logic        penable,
  output logic        pwrite,
  output logic [31:0] pwdata,
  output logic [3:0]  pstrb,
  input  logic [31:0] prdata,
  input  logic        pready
);

  logic        memReq;
  logic        memWrite;
  logic        memDone;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memStrobe;
  logic [31:0] memRdata;

  coreCtrlIf coreCtrl ();

  controlFsm i_controlFsm (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (coreCtrl.ctrl),
    .memReq  (memReq),
    .memWrite(memWrite),
    .memDone (memDone)
  );

  datapath #(
    .resetVector(resetVector)
  ) i_datapath (
    .clk         (clk),
    .reset       (reset),
    .dp          (coreCtrl.dp),
    .memAddr     (memAddr),
    .memWdata    (memWdata),
    .memStrobeOut(memStrobe),
    .memRdata    (memRdata),
    .memDone     (memDone)
  );

  apbRequester i_apbRequester (
    .clk      (clk),
    .reset    (reset),
    .memReq   (memReq),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memStrobe(memStrobe),
    .memDone  (memDone),
    .memRdata (memRdata),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .prdata   (prdata),
    .pready   (pready)
  );

endmodule

// File: bench/rvMulticycleTb.sv
/* RV32I multicycle core testbench */

`timescale 1ns/1ps

module rvMulticycleTb;

  localparam logic [31:0] resetAddr = 32'h0000_0000;
  localparam int numInstr   = 2000;
  localparam int cycleLimit = numInstr * 20;

  logic        clk;
  logic        reset;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;

  logic [31:0] mem [256];       // APB memory, code in the lower half
  logic [31:0] modelMem [256];
  logic [31:0] modelRegs [32];
  logic [31:0] modelPc;
  logic [31:0] rngState;
  logic [1:0]  expKind;         // next transfer: 0 fetch, 1 load, 2 store
  logic [31:0] expAddr;
  logic [31:0] expData;
  logic [3:0]  expStrb;
  logic        lastDone;
  int          waitLeft;
  int          cycles;
  int          instrCount;
  int          errorCounts [3]; // fetch, data, protocol

  rvMulticycle #(
    .resetVector(resetAddr)
  ) i_rvMulticycle (
    .clk    (clk),
    .reset  (reset),
    .paddr  (paddr),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .pstrb  (pstrb),
    .prdata (prdata),
    .pready (pready)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] laneBits(logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchCondition(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // random program in words 0..126, word 127 jumps back to 0
  task automatic writeProgram();
    logic [31:0] r;
    logic [31:0] g;
    logic [2:0]  f3;
    logic [1:0]  off;
    int          t;
    for (int k = 0; k < 256; k++) begin
      mem[k] = nextRandom();
    end
    for (int k = 0; k < 127; k++) begin
      r  = nextRandom();
      g  = nextRandom(); // rd [4:0], rs1 [9:5], rs2 [14:10], imm [26:15]
      f3 = r[10:8];
      t  = (r[15] && r[16]) ? k - 1 - int'(r[13:12]) : k + 1 + int'(r[14:12]);
      if (t > 127) t = 127;
      if (t < 0) t = k + 1;
      case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3:
          mem[k] = {((f3 == 3'd0 || f3 == 3'd5) && g[27]) ? 7'h20 : 7'h00,
                    g[14:10], g[9:5], f3, g[4:0], 7'b0110011};
        4'd4, 4'd5, 4'd6: begin
          if (f3 == 3'd1) g[26:15] = {7'h00, g[14:10]};
          if (f3 == 3'd5) g[26:15] = {1'b0, g[27], 5'h00, g[14:10]};
          mem[k] = encI(g[26:15], g[9:5], f3, g[4:0], 7'b0010011);
        end
        4'd7:  mem[k] = {g[31:12], g[4:0], r[4] ? 7'b0110111 : 7'b0010111};
        4'd8:  mem[k] = encI(g[26:15], g[9:5], 3'b010, g[4:0], 7'b0000011);
        4'd9: begin
          f3  = (r[5:4] == 2'd3) ? 3'd2 : {1'b0, r[5:4]};
          off = (f3 == 3'd0) ? g[1:0] : (f3 == 3'd1) ? {g[0], 1'b0} : 2'b00;
          g[26:15] = {3'b001, g[22:16], off}; // x0 base, data half only
          mem[k] = {g[26:20], g[14:10], 5'd0, f3, g[19:15], 7'b0100011};
        end
        4'd10, 4'd11: begin
          f3 = r[6:4] % 3'd6;
          if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip the two unused encodings
          mem[k] = encB(13'((t - k) * 4), g[14:10], g[9:5], f3);
        end
        4'd12: mem[k] = encJ(21'((t - k) * 4), g[4:0]);
        4'd13: mem[k] = encI(12'(t * 4) | {11'h0, r[7]}, 5'd0, 3'b000, g[4:0], 7'b1100111);
        4'd14: begin
          case (r[5:4])
            2'd0:    mem[k] = 32'h0ff0_000f; // fence
            2'd1:    mem[k] = 32'h0000_0073; // ecall
            default: mem[k] = {g[31:7], 7'b0001011};
          endcase
        end
        default: mem[k] = encI({{7{g[20]}}, g[19:15]}, g[9:5], 3'b000, g[4:0], 7'b0010011);
      endcase
    end
    mem[127] = encJ(-21'd508, 5'd0);
    for (int k = 0; k < 256; k++) begin
      modelMem[k] = mem[k];
    end
  endtask

  // one instruction of the reference model, sets up the next expected transfer
  task automatic executeModel(logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] rdVal;
    logic [31:0] next;
    logic        writeRd;
    a       = modelRegs[w[19:15]];
    b       = modelRegs[w[24:20]];
    immI    = {{20{w[31]}}, w[31:20]};
    next    = modelPc + 32'd4;
    rdVal   = next; // link value for jal and jalr
    writeRd = 1'b1;
    expKind = 2'd0;
    case (w[6:0])
      7'b0110111: rdVal = {w[31:12], 12'h000};
      7'b0010111: rdVal = modelPc + {w[31:12], 12'h000};
      7'b1101111: next = modelPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      7'b1100111: next = (a + immI) & ~32'h1;
      7'b1100011: begin
        writeRd = 1'b0;
        if (branchCondition(w[14:12], a, b)) begin
          next = modelPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b0000011: begin
        expKind = 2'd1;
        expAddr = a + immI;
        rdVal   = modelMem[expAddr[9:2]];
      end
      7'b0100011: begin
        writeRd = 1'b0;
        expKind = 2'd2;
        expAddr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        case (w[13:12])
          2'b00:   expStrb = 4'b0001 << expAddr[1:0];
          2'b01:   expStrb = 4'b0011 << expAddr[1:0];
          default: expStrb = 4'b1111;
        endcase
        expData = b << (8 * expAddr[1:0]);
        modelMem[expAddr[9:2]] = (modelMem[expAddr[9:2]] & ~laneBits(expStrb))
                               | (expData & laneBits(expStrb));
      end
      7'b0010011: rdVal = aluModel(w[14:12], w[14:12] == 3'b101 && w[30], a, immI);
      7'b0110011: rdVal = aluModel(w[14:12], w[30], a, b);
      default:    writeRd = 1'b0; // fence, system and unknown opcodes
    endcase
    if (writeRd && w[11:7] != 5'd0) modelRegs[w[11:7]] = rdVal;
    modelPc = next;
  endtask

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp, int cat);
    assert (got === exp) else begin
      errorCounts[cat]++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkTransfer();
    logic [31:0] m;
    m = laneBits(pstrb);
    if (pwrite) mem[paddr[9:2]] = (mem[paddr[9:2]] & ~m) | (pwdata & m);
    checkValue("pwrite", pwrite, expKind == 2'd2, (expKind == 2'd0) ? 0 : 1);
    if (expKind == 2'd0) begin
      checkValue("paddr", paddr, modelPc, 0);
      instrCount++;
      executeModel(modelMem[modelPc[9:2]]);
    end else begin
      checkValue("paddr", paddr, expAddr, 1);
      if (expKind == 2'd2) begin
        checkValue("pstrb", pstrb, expStrb, 1);
        checkValue("pwdata", pwdata & laneBits(expStrb), expData & laneBits(expStrb), 1);
      end
      expKind = 2'd0;
    end
  endtask

  // completer side, 0 to 3 wait cycles per transfer
  task automatic driveCompleter();
    pready = 1'b0;
    if (psel && !penable) begin
      waitLeft = int'(nextRandom() & 32'h3);
    end else if (psel && penable) begin
      if (waitLeft == 0) pready = 1'b1;
      else waitLeft--;
    end
    prdata = psel ? mem[paddr[9:2]] : nextRandom();
  endtask

  task automatic observeBus();
    if (lastDone) begin
      assert (!psel) else begin
        errorCounts[2]++;
        $display("psel stayed high in the cycle after a completed transfer at %0d ns", $time);
      end
    end
    assert (psel || !penable) else begin
      errorCounts[2]++;
      $display("penable was high without psel at %0d ns", $time);
    end
    if (psel && !pwrite) checkValue("pstrb", pstrb, 32'h0, 2);
    lastDone = psel && penable && pready;
    if (lastDone) checkTransfer();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    prdata      = 32'h0;
    pready      = 1'b0;
    rngState    = 32'h2d71_96bb;
    waitLeft    = 0;
    cycles      = 0;
    instrCount  = 0;
    lastDone    = 1'b0;
    expKind     = 2'd0;
    errorCounts = '{0, 0, 0};
    writeProgram();
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = 32'h0;
    end
    modelPc = resetAddr;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    while (instrCount < numInstr && cycles < cycleLimit) begin
      @(posedge clk);
      #1;
      cycles++;
      driveCompleter();
      @(negedge clk);
      observeBus();
    end
    if (instrCount < numInstr) begin
      $display("timeout: %0d of %0d instructions done after %0d cycles",
               instrCount, numInstr, cycles);
    end
    $write("summary: %0d instructions in %0d cycles, ", instrCount, cycles);
    $display("fetch errors %0d, data errors %0d, protocol errors %0d",
             errorCounts[0], errorCounts[1], errorCounts[2]);
    if (instrCount >= numInstr && errorCounts[0] + errorCounts[1] + errorCounts[2] == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: rvMulticycle.f
logic/rvCorePkg.sv
logic/coreCtrlIf.sv
logic/regFile.sv
logic/alu.sv
logic/controlFsm.sv
logic/datapath.sv
logic/apbRequester.sv
logic/rvMulticycle.sv
bench/rvMulticycleTb.sv

// File: Bender.yml
package:
  name: rvMulticycle

sources:
  - logic/rvCorePkg.sv
  - logic/coreCtrlIf.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/controlFsm.sv
  - logic/datapath.sv
  - logic/apbRequester.sv
  - logic/rvMulticycle.sv
  - target: simulation
    files:
      - bench/rvMulticycleTb.sv
